// ==== rtl/axis_pkg.sv ====
package axis_pkg;

    // --------------------
    // Beat geometry
    // --------------------

    // Default bytes per beat, kept small for simulation
    localparam int DATA_BYTES_DEF = 8;

    // --------------------
    // Sideband
    // --------------------

    // Packet id carried in tuser
    localparam int PID_WIDTH = 16;

    typedef logic [PID_WIDTH-1:0] pid_t;

endpackage : axis_pkg

// ==== rtl/smartnic_pkg.sv ====
package smartnic_pkg;

    // --------------------
    // Port identifiers
    // --------------------

    // Used for both tid and tdest
    // Host port of lane n is HOST0 + n
    typedef enum logic [1:0] {
        PHY0  = 2'd0,
        PHY1  = 2'd1,
        HOST0 = 2'd2,
        HOST1 = 2'd3
    } port_t;

    // Lanes on the card
    localparam int NUM_PORTS_DEF = 2;

    // --------------------
    // Egress arbitration
    // --------------------

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_APP,
        ARB_HOST
    } arb_state_t;

endpackage : smartnic_pkg

// ==== rtl/axis_if.sv ====
interface axis_if
    import axis_pkg::*;
    import smartnic_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF
) ();

    logic                    tvalid;
    logic                    tready;
    logic [DATA_BYTES*8-1:0] tdata;
    logic [DATA_BYTES-1:0]   tkeep;
    logic                    tlast;
    port_t                   tid;
    port_t                   tdest;
    pid_t                    tpid;

    // Source side
    modport tx (
        output tvalid, tdata, tkeep, tlast, tid, tdest, tpid,
        input  tready
    );

    // Sink side
    modport rx (
        input  tvalid, tdata, tkeep, tlast, tid, tdest, tpid,
        output tready
    );

endinterface : axis_if

// ==== rtl/igr_demux.sv ====
module igr_demux
    import axis_pkg::*;
    import smartnic_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF,
    parameter int LANE       = 0
) (
    input  logic core_clk,
    input  logic arst_n,
    axis_if.rx   igr,
    axis_if.tx   c2h,
    axis_if.tx   app
);

    // Host queue owned by this lane
    localparam port_t HOST_PORT = port_t'(int'(HOST0) + LANE);

    logic in_pkt;
    logic route_host_q;
    logic route_host;
    logic igr_xfer;

    // --------------------
    // Route selection
    // --------------------

    // First beat decides, later beats follow the stored choice
    assign route_host = in_pkt ? route_host_q : (igr.tdest == HOST_PORT);
    assign igr_xfer   = igr.tvalid && igr.tready;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt       <= 1'b0;
            route_host_q <= 1'b0;
        end else if (igr_xfer) begin
            in_pkt       <= !igr.tlast;
            route_host_q <= route_host;
        end
    end

    // --------------------
    // Stream steering
    // --------------------

    assign c2h.tvalid = igr.tvalid && route_host;
    assign app.tvalid = igr.tvalid && !route_host;

    assign igr.tready = route_host ? c2h.tready : app.tready;

    // Byte enables only on the selected side
    assign c2h.tkeep = igr.tkeep & {DATA_BYTES{route_host}};
    assign app.tkeep = igr.tkeep & {DATA_BYTES{!route_host}};

    assign c2h.tdata = igr.tdata;
    assign c2h.tlast = igr.tlast;
    assign c2h.tid   = igr.tid;
    assign c2h.tdest = igr.tdest;
    assign c2h.tpid  = igr.tpid;

    assign app.tdata = igr.tdata;
    assign app.tlast = igr.tlast;
    assign app.tid   = igr.tid;
    assign app.tdest = igr.tdest;
    assign app.tpid  = igr.tpid;

endmodule : igr_demux

// ==== rtl/axis_pipe.sv ====
module axis_pipe
    import axis_pkg::*;
    import smartnic_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF
) (
    input  logic core_clk,
    input  logic arst_n,
    axis_if.rx   in_s,
    axis_if.tx   out_m
);

    // Application processing stage, two beats of storage
    logic [DATA_BYTES*8-1:0] data_q [2];
    logic [DATA_BYTES-1:0]   keep_q [2];
    logic [1:0]              last_q;
    port_t                   id_q   [2];
    port_t                   dest_q [2];
    pid_t                    pid_q  [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // Ready drops only once both entries hold a beat
    assign in_s.tready = (count != 2'd2);
    assign push        = in_s.tvalid && in_s.tready;
    assign pop         = out_m.tvalid && out_m.tready;

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge core_clk) begin
        if (push) begin
            data_q[wr_ptr] <= in_s.tdata;
            keep_q[wr_ptr] <= in_s.tkeep;
            last_q[wr_ptr] <= in_s.tlast;
            id_q[wr_ptr]   <= in_s.tid;
            dest_q[wr_ptr] <= in_s.tdest;
            pid_q[wr_ptr]  <= in_s.tpid;
        end
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop) rd_ptr <= !rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    // Head entry drives the output
    assign out_m.tvalid = (count != 2'd0);
    assign out_m.tdata  = data_q[rd_ptr];
    assign out_m.tkeep  = keep_q[rd_ptr];
    assign out_m.tlast  = last_q[rd_ptr];
    assign out_m.tid    = id_q[rd_ptr];
    assign out_m.tdest  = dest_q[rd_ptr];
    assign out_m.tpid   = pid_q[rd_ptr];

endmodule : axis_pipe

// ==== rtl/egr_arbiter.sv ====
module egr_arbiter
    import smartnic_pkg::*;
(
    input  logic core_clk,
    input  logic arst_n,
    input  logic app_req,
    input  logic host_req,
    input  logic pkt_done,
    output logic grant_app,
    output logic grant_host
);

    arb_state_t state;
    arb_state_t state_nxt;

    // Set when the host source had the last grant
    logic last_host;

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                if (app_req && host_req) begin
                    // Both pending, serve the other one this time
                    state_nxt = last_host ? ARB_APP : ARB_HOST;
                end else if (app_req) begin
                    state_nxt = ARB_APP;
                end else if (host_req) begin
                    state_nxt = ARB_HOST;
                end
            end
            ARB_APP, ARB_HOST: begin
                if (pkt_done) state_nxt = ARB_IDLE;
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ARB_IDLE;
            last_host <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ARB_IDLE && state_nxt != ARB_IDLE) begin
                last_host <= (state_nxt == ARB_HOST);
            end
        end
    end

    // Grants come straight from the state register
    assign grant_app  = (state == ARB_APP);
    assign grant_host = (state == ARB_HOST);

endmodule : egr_arbiter

// ==== rtl/egr_mux.sv ====
module egr_mux
    import axis_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF
) (
    axis_if.rx   app,
    axis_if.rx   host,
    axis_if.tx   egr,
    input  logic grant_app,
    input  logic grant_host,
    output logic pkt_done
);

    // --------------------
    // Payload select
    // --------------------

    // Grants are one-hot or zero, so an AND-OR select is enough
    assign egr.tvalid = (grant_app && app.tvalid) || (grant_host && host.tvalid);
    assign egr.tlast  = (grant_app && app.tlast) || (grant_host && host.tlast);

    assign egr.tdata = ({(DATA_BYTES*8){grant_app}} & app.tdata)
                     | ({(DATA_BYTES*8){grant_host}} & host.tdata);
    assign egr.tkeep = ({DATA_BYTES{grant_app}} & app.tkeep)
                     | ({DATA_BYTES{grant_host}} & host.tkeep);
    assign egr.tpid  = ({PID_WIDTH{grant_app}} & app.tpid)
                     | ({PID_WIDTH{grant_host}} & host.tpid);

    assign egr.tid   = grant_host ? host.tid : app.tid;
    assign egr.tdest = grant_host ? host.tdest : app.tdest;

    // Only the granted source sees ready
    assign app.tready  = grant_app && egr.tready;
    assign host.tready = grant_host && egr.tready;

    // Last beat of the granted packet has left
    assign pkt_done = egr.tvalid && egr.tready && egr.tlast;

endmodule : egr_mux

// ==== rtl/smartnic_app.sv ====
module smartnic_app
    import axis_pkg::*;
    import smartnic_pkg::*;
#(
    parameter int NUM_PORTS  = NUM_PORTS_DEF,
    parameter int DATA_BYTES = DATA_BYTES_DEF
) (
    input  logic core_clk,
    input  logic arst_n,

    // Ingress from the network side
    input  logic [NUM_PORTS-1:0]                axis_app_igr_tvalid,
    output logic [NUM_PORTS-1:0]                axis_app_igr_tready,
    input  logic [NUM_PORTS*DATA_BYTES*8-1:0]   axis_app_igr_tdata,
    input  logic [NUM_PORTS*DATA_BYTES-1:0]     axis_app_igr_tkeep,
    input  logic [NUM_PORTS-1:0]                axis_app_igr_tlast,
    input  logic [NUM_PORTS*$bits(port_t)-1:0]  axis_app_igr_tid,
    input  logic [NUM_PORTS*$bits(port_t)-1:0]  axis_app_igr_tdest,
    input  logic [NUM_PORTS*PID_WIDTH-1:0]      axis_app_igr_tuser_pid,

    // Host to card
    input  logic [NUM_PORTS-1:0]                axis_h2c_tvalid,
    output logic [NUM_PORTS-1:0]                axis_h2c_tready,
    input  logic [NUM_PORTS*DATA_BYTES*8-1:0]   axis_h2c_tdata,
    input  logic [NUM_PORTS*DATA_BYTES-1:0]     axis_h2c_tkeep,
    input  logic [NUM_PORTS-1:0]                axis_h2c_tlast,
    input  logic [NUM_PORTS*$bits(port_t)-1:0]  axis_h2c_tid,
    input  logic [NUM_PORTS*$bits(port_t)-1:0]  axis_h2c_tdest,
    input  logic [NUM_PORTS*PID_WIDTH-1:0]      axis_h2c_tuser_pid,

    // Egress toward the network side
    output logic [NUM_PORTS-1:0]                axis_app_egr_tvalid,
    input  logic [NUM_PORTS-1:0]                axis_app_egr_tready,
    output logic [NUM_PORTS*DATA_BYTES*8-1:0]   axis_app_egr_tdata,
    output logic [NUM_PORTS*DATA_BYTES-1:0]     axis_app_egr_tkeep,
    output logic [NUM_PORTS-1:0]                axis_app_egr_tlast,
    output logic [NUM_PORTS*$bits(port_t)-1:0]  axis_app_egr_tid,
    output logic [NUM_PORTS*$bits(port_t)-1:0]  axis_app_egr_tdest,
    output logic [NUM_PORTS*PID_WIDTH-1:0]      axis_app_egr_tuser_pid,

    // Card to host
    output logic [NUM_PORTS-1:0]                axis_c2h_tvalid,
    input  logic [NUM_PORTS-1:0]                axis_c2h_tready,
    output logic [NUM_PORTS*DATA_BYTES*8-1:0]   axis_c2h_tdata,
    output logic [NUM_PORTS*DATA_BYTES-1:0]     axis_c2h_tkeep,
    output logic [NUM_PORTS-1:0]                axis_c2h_tlast,
    output logic [NUM_PORTS*$bits(port_t)-1:0]  axis_c2h_tid,
    output logic [NUM_PORTS*$bits(port_t)-1:0]  axis_c2h_tdest,
    output logic [NUM_PORTS*PID_WIDTH-1:0]      axis_c2h_tuser_pid
);

    localparam int DW = DATA_BYTES * 8;
    localparam int PW = $bits(port_t);

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_lane
        axis_if #(.DATA_BYTES(DATA_BYTES)) igr ();
        axis_if #(.DATA_BYTES(DATA_BYTES)) c2h ();
        axis_if #(.DATA_BYTES(DATA_BYTES)) app_in ();
        axis_if #(.DATA_BYTES(DATA_BYTES)) app_out ();
        axis_if #(.DATA_BYTES(DATA_BYTES)) h2c ();
        axis_if #(.DATA_BYTES(DATA_BYTES)) egr ();

        logic grant_app;
        logic grant_host;
        logic pkt_done;

        // --------------------
        // Flat ports to lane streams
        // --------------------
        assign igr.tvalid             = axis_app_igr_tvalid[g];
        assign igr.tdata              = axis_app_igr_tdata[g*DW +: DW];
        assign igr.tkeep              = axis_app_igr_tkeep[g*DATA_BYTES +: DATA_BYTES];
        assign igr.tlast              = axis_app_igr_tlast[g];
        assign igr.tid                = port_t'(axis_app_igr_tid[g*PW +: PW]);
        assign igr.tdest              = port_t'(axis_app_igr_tdest[g*PW +: PW]);
        assign igr.tpid               = axis_app_igr_tuser_pid[g*PID_WIDTH +: PID_WIDTH];
        assign axis_app_igr_tready[g] = igr.tready;

        assign h2c.tvalid         = axis_h2c_tvalid[g];
        assign h2c.tdata          = axis_h2c_tdata[g*DW +: DW];
        assign h2c.tkeep          = axis_h2c_tkeep[g*DATA_BYTES +: DATA_BYTES];
        assign h2c.tlast          = axis_h2c_tlast[g];
        assign h2c.tid            = port_t'(axis_h2c_tid[g*PW +: PW]);
        assign h2c.tdest          = port_t'(axis_h2c_tdest[g*PW +: PW]);
        assign h2c.tpid           = axis_h2c_tuser_pid[g*PID_WIDTH +: PID_WIDTH];
        assign axis_h2c_tready[g] = h2c.tready;

        assign axis_app_egr_tvalid[g]                            = egr.tvalid;
        assign axis_app_egr_tdata[g*DW +: DW]                    = egr.tdata;
        assign axis_app_egr_tkeep[g*DATA_BYTES +: DATA_BYTES]    = egr.tkeep;
        assign axis_app_egr_tlast[g]                             = egr.tlast;
        assign axis_app_egr_tid[g*PW +: PW]                      = egr.tid;
        assign axis_app_egr_tdest[g*PW +: PW]                    = egr.tdest;
        assign axis_app_egr_tuser_pid[g*PID_WIDTH +: PID_WIDTH]  = egr.tpid;
        assign egr.tready                                        = axis_app_egr_tready[g];

        assign axis_c2h_tvalid[g]                           = c2h.tvalid;
        assign axis_c2h_tdata[g*DW +: DW]                   = c2h.tdata;
        assign axis_c2h_tkeep[g*DATA_BYTES +: DATA_BYTES]   = c2h.tkeep;
        assign axis_c2h_tlast[g]                            = c2h.tlast;
        assign axis_c2h_tid[g*PW +: PW]                     = c2h.tid;
        assign axis_c2h_tdest[g*PW +: PW]                   = c2h.tdest;
        assign axis_c2h_tuser_pid[g*PID_WIDTH +: PID_WIDTH] = c2h.tpid;
        assign c2h.tready                                   = axis_c2h_tready[g];

        // --------------------
        // Lane datapath
        // --------------------
        igr_demux #(.DATA_BYTES(DATA_BYTES), .LANE(g)) i_igr_demux (
            .core_clk ( core_clk ),
            .arst_n   ( arst_n ),
            .igr      ( igr ),
            .c2h      ( c2h ),
            .app      ( app_in )
        );

        axis_pipe #(.DATA_BYTES(DATA_BYTES)) i_axis_pipe (
            .core_clk ( core_clk ),
            .arst_n   ( arst_n ),
            .in_s     ( app_in ),
            .out_m    ( app_out )
        );

        egr_arbiter i_egr_arbiter (
            .core_clk   ( core_clk ),
            .arst_n     ( arst_n ),
            .app_req    ( app_out.tvalid ),
            .host_req   ( h2c.tvalid ),
            .pkt_done   ( pkt_done ),
            .grant_app  ( grant_app ),
            .grant_host ( grant_host )
        );

        egr_mux #(.DATA_BYTES(DATA_BYTES)) i_egr_mux (
            .app        ( app_out ),
            .host       ( h2c ),
            .egr        ( egr ),
            .grant_app  ( grant_app ),
            .grant_host ( grant_host ),
            .pkt_done   ( pkt_done )
        );
    end

endmodule : smartnic_app

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic core_clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    // Reset low for the first two rising edges
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge core_clk);
        #1 arst_n = 1'b1;
    end

endmodule : tb_clk_gen

// ==== verif/tb_checker.sv ====
module tb_checker
    import smartnic_pkg::*;
#(
    parameter int NUM_PORTS  = NUM_PORTS_DEF,
    parameter int DATA_BYTES = 8
) (
    input  logic                                   core_clk,
    input  logic                                   arst_n,
    input  logic                                   sat,
    // Stream 0 ingress, 1 h2c, 2 egress, 3 c2h
    input  logic [3:0][NUM_PORTS-1:0]              tvalid,
    input  logic [3:0][NUM_PORTS-1:0]              tready,
    input  logic [3:0][NUM_PORTS*DATA_BYTES*8-1:0] tdata,
    input  logic [3:0][NUM_PORTS*DATA_BYTES-1:0]   tkeep,
    input  logic [3:0][NUM_PORTS-1:0]              tlast,
    input  logic [3:0][NUM_PORTS*2-1:0]            tid,
    input  logic [3:0][NUM_PORTS*2-1:0]            tdest,
    input  logic [3:0][NUM_PORTS*16-1:0]           tpid,
    output int                                     errors,
    output int                                     pkts,
    output int                                     pending
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW       = DATA_BYTES * 8;
    localparam int BW       = DW + DATA_BYTES + 21;
    localparam int LAST_BIT = 20;

    // Expected beats of every lane, tagged lane * 3 + queue
    // Queue 0 is c2h, 1 is application, 2 is h2c
    logic [BW-1:0] beat_q [$];
    int            tag_q  [$];

    logic [NUM_PORTS-1:0] in_pkt;
    logic [NUM_PORTS-1:0] to_host;
    logic [NUM_PORTS-1:0] out_pkt;
    int                   out_src  [NUM_PORTS];
    int                   last_src [NUM_PORTS];
    logic                 traffic_seen;

    function automatic logic [BW-1:0] beat_of(input int s, input int l);
        return {tdata[s][l*DW +: DW], tkeep[s][l*DATA_BYTES +: DATA_BYTES], tlast[s][l],
                tid[s][l*2 +: 2], tdest[s][l*2 +: 2], tpid[s][l*16 +: 16]};
    endfunction

    function automatic int head_of(input int tag);
        for (int i = 0; i < tag_q.size(); i++) begin
            if (tag_q[i] == tag) return i;
        end
        return -1;
    endfunction

    task automatic check_beat(input string where, input int l, input int tag,
                              input logic [BW-1:0] got);
        string test;
        int    idx;
        test = sat ? "fairness" : "traffic";
        idx  = head_of(tag);
        if (idx < 0) begin
            $display("%s lane %0d sent a beat while no packet was expected", where, l);
            errors++;
        end else begin
            if (beat_q[idx] !== got) begin
                $display("[FAIL] %s %s lane %0d expected %h actual %h",
                         test, where, l, beat_q[idx], got);
                errors++;
            end
            beat_q.delete(idx);
            tag_q.delete(idx);
        end
        if (got[LAST_BIT]) pkts++;
    endtask

    // --------------------
    // Sampling at the falling edge, where every stream is stable
    // --------------------

    always @(negedge core_clk) begin
        int ia;
        int ih;
        if (!arst_n) begin
            in_pkt       = '0;
            to_host      = '0;
            out_pkt      = '0;
            traffic_seen = 1'b0;
        end else begin
            if (|tvalid[1:0]) traffic_seen = 1'b1;
            if (!traffic_seen && |tvalid[3:2]) begin
                $display("egress or c2h raised tvalid after reset before any traffic");
                errors++;
            end
            for (int l = 0; l < NUM_PORTS; l++) begin
                if (!sat) last_src[l] = 0;
                // First beat picks the route for the whole packet
                if (tvalid[0][l] && tready[0][l]) begin
                    if (!in_pkt[l]) to_host[l] = (tdest[0][l*2 +: 2] == HOST0 + l);
                    beat_q.push_back(beat_of(0, l));
                    tag_q.push_back(l * 3 + (to_host[l] ? 0 : 1));
                    in_pkt[l] = !tlast[0][l];
                end
                if (tvalid[1][l] && tready[1][l]) begin
                    beat_q.push_back(beat_of(1, l));
                    tag_q.push_back(l * 3 + 2);
                end
                if (tvalid[3][l] && tready[3][l]) check_beat("c2h", l, l * 3, beat_of(3, l));
                if (tvalid[2][l] && tready[2][l]) begin
                    if (!out_pkt[l]) begin
                        ia = head_of(l * 3 + 1);
                        ih = head_of(l * 3 + 2);
                        out_src[l] = (ih < 0 || (ia >= 0 && beat_q[ia] == beat_of(2, l))) ? 1 : 2;
                        if (last_src[l] == out_src[l]) begin
                            $display("[FAIL] fairness lane %0d expected %s actual %s", l,
                                     out_src[l] == 1 ? "h2c" : "app",
                                     out_src[l] == 1 ? "app" : "h2c");
                            errors++;
                        end
                        if (sat) last_src[l] = out_src[l];
                    end
                    check_beat("egress", l, l * 3 + out_src[l], beat_of(2, l));
                    out_pkt[l] = !tlast[2][l];
                end
            end
            pending = beat_q.size();
        end
    end

endmodule : tb_checker

// ==== verif/tb_smartnic_app.sv ====
module tb_smartnic_app
    import smartnic_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS  = 2;
    localparam int DATA_BYTES = 8;
    localparam int DW         = DATA_BYTES * 8;
    localparam int SEED       = 46895;
    localparam int RAND_PKTS  = 40;
    localparam int SAT_PKTS   = 12;
    localparam int MAX_BEATS  = 8;
    // Two sources per lane, each running both phases
    localparam int TOTAL_PKTS = NUM_PORTS * 2 * (RAND_PKTS + SAT_PKTS);
    localparam int LIMIT      = TOTAL_PKTS * MAX_BEATS * 4 + 200;

    logic core_clk;
    logic arst_n;
    logic sat;
    int   cycles;
    int   errors;
    int   pkts;
    int   pending;
    int   mark_err;
    int   mark_pkt;

    // Index 0 is ingress, 1 is h2c
    logic [1:0][NUM_PORTS-1:0]            src_tvalid;
    wire  [1:0][NUM_PORTS-1:0]            src_tready;
    logic [1:0][NUM_PORTS*DW-1:0]         src_tdata;
    logic [1:0][NUM_PORTS*DATA_BYTES-1:0] src_tkeep;
    logic [1:0][NUM_PORTS-1:0]            src_tlast;
    logic [1:0][NUM_PORTS*2-1:0]          src_tid;
    logic [1:0][NUM_PORTS*2-1:0]          src_tdest;
    logic [1:0][NUM_PORTS*16-1:0]         src_tpid;

    // Index 0 is egress, 1 is c2h
    wire  [1:0][NUM_PORTS-1:0]            dst_tvalid;
    logic [1:0][NUM_PORTS-1:0]            dst_tready;
    wire  [1:0][NUM_PORTS*DW-1:0]         dst_tdata;
    wire  [1:0][NUM_PORTS*DATA_BYTES-1:0] dst_tkeep;
    wire  [1:0][NUM_PORTS-1:0]            dst_tlast;
    wire  [1:0][NUM_PORTS*2-1:0]          dst_tid;
    wire  [1:0][NUM_PORTS*2-1:0]          dst_tdest;
    wire  [1:0][NUM_PORTS*16-1:0]         dst_tpid;

    tb_clk_gen i_clk_gen (
        .core_clk ( core_clk ),
        .arst_n   ( arst_n )
    );

    smartnic_app #(
        .NUM_PORTS  ( NUM_PORTS ),
        .DATA_BYTES ( DATA_BYTES )
    ) i_smartnic_app (
        .core_clk               ( core_clk ),
        .arst_n                 ( arst_n ),
        .axis_app_igr_tvalid    ( src_tvalid[0] ),
        .axis_app_igr_tready    ( src_tready[0] ),
        .axis_app_igr_tdata     ( src_tdata[0] ),
        .axis_app_igr_tkeep     ( src_tkeep[0] ),
        .axis_app_igr_tlast     ( src_tlast[0] ),
        .axis_app_igr_tid       ( src_tid[0] ),
        .axis_app_igr_tdest     ( src_tdest[0] ),
        .axis_app_igr_tuser_pid ( src_tpid[0] ),
        .axis_h2c_tvalid        ( src_tvalid[1] ),
        .axis_h2c_tready        ( src_tready[1] ),
        .axis_h2c_tdata         ( src_tdata[1] ),
        .axis_h2c_tkeep         ( src_tkeep[1] ),
        .axis_h2c_tlast         ( src_tlast[1] ),
        .axis_h2c_tid           ( src_tid[1] ),
        .axis_h2c_tdest         ( src_tdest[1] ),
        .axis_h2c_tuser_pid     ( src_tpid[1] ),
        .axis_app_egr_tvalid    ( dst_tvalid[0] ),
        .axis_app_egr_tready    ( dst_tready[0] ),
        .axis_app_egr_tdata     ( dst_tdata[0] ),
        .axis_app_egr_tkeep     ( dst_tkeep[0] ),
        .axis_app_egr_tlast     ( dst_tlast[0] ),
        .axis_app_egr_tid       ( dst_tid[0] ),
        .axis_app_egr_tdest     ( dst_tdest[0] ),
        .axis_app_egr_tuser_pid ( dst_tpid[0] ),
        .axis_c2h_tvalid        ( dst_tvalid[1] ),
        .axis_c2h_tready        ( dst_tready[1] ),
        .axis_c2h_tdata         ( dst_tdata[1] ),
        .axis_c2h_tkeep         ( dst_tkeep[1] ),
        .axis_c2h_tlast         ( dst_tlast[1] ),
        .axis_c2h_tid           ( dst_tid[1] ),
        .axis_c2h_tdest         ( dst_tdest[1] ),
        .axis_c2h_tuser_pid     ( dst_tpid[1] )
    );

    tb_checker #(
        .NUM_PORTS  ( NUM_PORTS ),
        .DATA_BYTES ( DATA_BYTES )
    ) i_checker (
        .core_clk ( core_clk ),
        .arst_n   ( arst_n ),
        .sat      ( sat ),
        .tvalid   ( {dst_tvalid, src_tvalid} ),
        .tready   ( {dst_tready, src_tready} ),
        .tdata    ( {dst_tdata, src_tdata} ),
        .tkeep    ( {dst_tkeep, src_tkeep} ),
        .tlast    ( {dst_tlast, src_tlast} ),
        .tid      ( {dst_tid, src_tid} ),
        .tdest    ( {dst_tdest, src_tdest} ),
        .tpid     ( {dst_tpid, src_tpid} ),
        .errors   ( errors ),
        .pkts     ( pkts ),
        .pending  ( pending )
    );

    // --------------------
    // Stimulus
    // --------------------

    // Holds the beat until the handshake, sampled at the falling edge
    task automatic wait_accept(input int s, input int l);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge core_clk);
            done = src_tready[s][l];
            @(posedge core_clk);
        end
        #1;
    endtask

    task automatic run_stream(input int s, input int l, input int n);
        int            len;
        logic [DW-1:0] data;
        for (int p = 0; p < n; p++) begin
            if (!sat) begin
                repeat ($urandom_range(3)) begin
                    @(posedge core_clk);
                    #1;
                end
            end
            len = $urandom_range(MAX_BEATS, 1);
            // Saturated ingress stays on the application path
            src_tdest[s][l*2 +: 2] = (sat && s == 0) ? $urandom_range(1) : $urandom_range(3);
            src_tid[s][l*2 +: 2]   = (s == 0) ? 2'(PHY0 + l) : 2'(HOST0 + l);
            src_tpid[s][l*16 +: 16] = $urandom;
            for (int b = 0; b < len; b++) begin
                for (int i = 0; i < DATA_BYTES; i++) data[i*8 +: 8] = $urandom;
                src_tdata[s][l*DW +: DW]                 = data;
                src_tkeep[s][l*DATA_BYTES +: DATA_BYTES] = $urandom;
                src_tlast[s][l]                          = (b == len - 1);
                src_tvalid[s][l]                         = 1'b1;
                wait_accept(s, l);
            end
            src_tvalid[s][l] = 1'b0;
        end
    endtask

    task automatic run_phase(input int n);
        for (int l = 0; l < NUM_PORTS; l++) begin
            for (int s = 0; s < 2; s++) begin
                automatic int fl = l;
                automatic int fs = s;
                fork
                    run_stream(fs, fl, n);
                join_none
            end
        end
        wait fork;
        while (pending != 0) @(posedge core_clk);
        #1;
    endtask

    task automatic show_result(input string name);
        $display("test %s: %0d packets, %0d errors", name, pkts - mark_pkt, errors - mark_err);
        mark_pkt = pkts;
        mark_err = errors;
    endtask

    // Random back-pressure on egress and c2h
    initial begin
        forever begin
            @(posedge core_clk);
            #1;
            for (int l = 0; l < NUM_PORTS; l++) begin
                dst_tready[0][l] = sat || ($urandom_range(3) != 0);
                dst_tready[1][l] = sat || ($urandom_range(3) != 0);
            end
        end
    end

    initial begin
        int seed_val;
        sat        = 1'b0;
        mark_err   = 0;
        mark_pkt   = 0;
        src_tvalid = '0;
        src_tdata  = '0;
        src_tkeep  = '0;
        src_tlast  = '0;
        src_tid    = '0;
        src_tdest  = '0;
        src_tpid   = '0;
        dst_tready = '0;
        seed_val   = $urandom(SEED);
        @(posedge arst_n);
        // Quiet window, outputs must stay idle
        repeat (4) @(posedge core_clk);
        #1;
        show_result("reset");
        run_phase(RAND_PKTS);
        show_result("traffic");
        sat = 1'b1;
        run_phase(SAT_PKTS);
        show_result("fairness");
        $display("tests 3, packets %0d, errors %0d", pkts, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // --------------------
    // Timeout
    // --------------------

    always @(posedge core_clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles with %0d beats still expected", cycles, pending);
            $display("Testbench failed");
            $finish;
        end
    end

endmodule : tb_smartnic_app

// ==== build.f ====
rtl/axis_pkg.sv
rtl/smartnic_pkg.sv
rtl/axis_if.sv
rtl/igr_demux.sv
rtl/axis_pipe.sv
rtl/egr_arbiter.sv
rtl/egr_mux.sv
rtl/smartnic_app.sv
verif/tb_clk_gen.sv
verif/tb_checker.sv
verif/tb_smartnic_app.sv

// ==== Bender.yml ====
package:
  name: smartnic_app

sources:
  - rtl/axis_pkg.sv
  - rtl/smartnic_pkg.sv
  - rtl/axis_if.sv
  - rtl/igr_demux.sv
  - rtl/axis_pipe.sv
  - rtl/egr_arbiter.sv
  - rtl/egr_mux.sv
  - rtl/smartnic_app.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_checker.sv
      - verif/tb_smartnic_app.sv
